/* src.f */
rtl/cart_pkg.sv
rtl/snes_bus_sync.sv
rtl/cart_map.sv
rtl/rom_arbiter.sv
rtl/psram_port.sv
rtl/cart_main.sv
test/cart_main_sva.sv
test/cart_main_tb.sv

/* Makefile */
# Verilator simulation of the cartridge core

.PHONY: sim clean

sim:
	verilator --binary --timing --assert -j 0 --top-module cart_main_tb \
		-f src.f -o sim_cart_main
	./obj_dir/sim_cart_main

clean:
	rm -rf obj_dir

/* test/cart_main_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module cart_main_tb
  import cart_pkg::*;
();

  localparam snes_addr_t ROM_MASK  = 24'h3FFFFF;  // 4 MB of ROM
  localparam snes_addr_t SRAM_MASK = 24'h001FFF;  // 8 KB of save RAM
  localparam int N_RD  = 16;
  localparam int N_WR  = 12;
  localparam int N_MCU = 12;
  localparam int N_MIX = 6;
  localparam int N_TESTS = N_RD + 2 * N_WR + N_MCU + N_MIX;

  localparam logic [2:0] K_SNES  = 3'd0;
  localparam logic [2:0] K_MCU   = 3'd1;
  localparam logic [2:0] K_MEM   = 3'd2;
  localparam logic [2:0] K_RESET = 3'd3;
  localparam logic [2:0] K_BUS   = 3'd4;

  typedef struct packed {
    logic [2:0] kind;
    snes_addr_t addr;
    byte_t      exp;
  } chk_t;

  logic           CLK2;
  logic           rst_n;
  snes_addr_t     snes_addr_in;
  logic           snes_rd_n;
  logic           snes_wr_n;
  logic           snes_cs_n;
  logic           snes_cpu_clk;
  byte_t          snes_din;
  byte_t          snes_dout;
  logic           snes_dout_en;
  logic           snes_databus_oe_n;
  logic           snes_databus_dir;
  rom_word_addr_t rom_addr;
  rom_word_t      rom_dq_in;
  rom_word_t      rom_dq_out;
  logic           rom_dq_oe;
  logic           rom_we_n;
  logic           rom_bhe_n;
  logic           rom_ble_n;
  logic           mcu_rrq;
  logic           mcu_wrq;
  snes_addr_t     mcu_addr;
  byte_t          mcu_dout;
  byte_t          mcu_din;
  logic           mcu_rdy;
  snes_addr_t     rom_mask;
  snes_addr_t     saveram_mask;

  rom_word_t  mem [0:32767];    // PSRAM model
  byte_t      shadow [0:65535]; // Expected bytes, same aliasing as the model
  chk_t       chk_q [$];
  chk_t       cur;
  byte_t      got;
  rom_word_t  w;
  integer     seed;
  int         r;
  snes_addr_t a;
  snes_addr_t wr_addrs [$];

  cart_main #(.DEAD_TIMEOUT(18'd40)) UUT (.*);

  initial begin
    CLK2 = 1'b0;
    forever #50 CLK2 = ~CLK2;
  end

  ////////////////////
  // PSRAM model

  function automatic rom_word_t fill_word(input logic [14:0] i);
    return ({1'b0, i} * 16'h9e37) ^ {i[7:0], i[14:7]};
  endfunction

  assign rom_dq_in = mem[rom_addr[14:0]];

  initial begin
    for (int i = 0; i < 32768; i++) mem[i[14:0]] = fill_word(i[14:0]);
    forever begin
      @(posedge rom_we_n);  // Byte lands on the rising strobe
      if (rst_n) begin
        if (!rom_ble_n) mem[rom_addr[14:0]][7:0] = rom_dq_out[7:0];
        if (!rom_bhe_n) mem[rom_addr[14:0]][15:8] = rom_dq_out[15:8];
      end
    end
  end

  function automatic byte_t model_byte(input logic [15:0] b);
    if (b[0]) return mem[b[15:1]][7:0];  // Odd bytes in the low lane
    else return mem[b[15:1]][15:8];
  endfunction

  ////////////////////
  // Reference map

  function automatic logic in_saveram(input snes_addr_t s);
    return (s[23:16] >= 8'h70) && (s[23:16] <= 8'h7D) && !s[15];
  endfunction

  function automatic logic in_rom(input snes_addr_t s);
    return s[15] || ((s[23:16] >= 8'h40) && (s[23:16] <= 8'h6F))
        || (s[23:16] >= 8'hC0);
  endfunction

  function automatic snes_addr_t exp_map(input snes_addr_t s);
    snes_addr_t low;
    low = {4'h0, s[20:16], s[14:0]};
    if (in_saveram(s)) return 24'hE00000 + (low & SRAM_MASK);
    return {2'b00, s[22:16], s[14:0]} & ROM_MASK;  // LoROM fold
  endfunction

  ////////////////////
  // Failure reporting

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("Some tests failed");
    $fatal(1, "Run aborted");
  endtask

  task automatic report_mismatch(input string sig, input byte_t g, input byte_t e);
    abort_run($sformatf("Fail %s: got 0x%02h, expected 0x%02h", sig, g, e));
  endtask

  task automatic push_check(input logic [2:0] kind, input snes_addr_t s, input byte_t e);
    chk_t c;
    c.kind = kind;
    c.addr = s;
    c.exp  = e;
    chk_q.push_back(c);
  endtask

  // Compare at the falling edge, outputs settled
  always @(negedge CLK2) begin
    while (chk_q.size() > 0) begin
      cur = chk_q.pop_front();
      case (cur.kind)
        K_SNES: assert (snes_dout == cur.exp)
          else report_mismatch("snes_dout", snes_dout, cur.exp);
        K_MCU: assert (mcu_din == cur.exp)
          else report_mismatch("mcu_din", mcu_din, cur.exp);
        K_MEM: begin
          got = model_byte(cur.addr[15:0]);
          assert (got == cur.exp)
            else report_mismatch($sformatf("psram byte 0x%04h", cur.addr[15:0]), got, cur.exp);
        end
        K_BUS: assert ({5'h0, snes_dout_en, snes_databus_dir, snes_databus_oe_n} == cur.exp)
          else report_mismatch("{snes_dout_en,snes_databus_dir,snes_databus_oe_n}",
                               {5'h0, snes_dout_en, snes_databus_dir, snes_databus_oe_n},
                               cur.exp);
        default: assert ({4'h0, mcu_rdy, rom_we_n, rom_dq_oe, snes_dout_en} == cur.exp)
          else report_mismatch("{mcu_rdy,rom_we_n,rom_dq_oe,snes_dout_en}",
                               {4'h0, mcu_rdy, rom_we_n, rom_dq_oe, snes_dout_en}, cur.exp);
      endcase
    end
  end

  ////////////////////
  // Bus stimulus

  // One CPU cycle, 12 low and 12 high
  task automatic snes_cycle(input snes_addr_t s, input logic wr, input byte_t d);
    snes_addr_t m;
    logic       oe_n;
    m = exp_map(s);
    snes_addr_in <= s;
    snes_cpu_clk <= 1'b0;
    if (wr) begin
      snes_wr_n <= 1'b0;
      snes_din  <= d;
    end else begin
      snes_rd_n <= 1'b0;
    end
    repeat (11) @(posedge CLK2);
    // Transceiver open while the strobe is held
    oe_n = !((in_rom(s) && !snes_cs_n) || in_saveram(s));
    push_check(K_BUS, s, {5'h0, !wr, !wr, oe_n});
    @(posedge CLK2);
    snes_rd_n    <= 1'b1;
    snes_wr_n    <= 1'b1;
    snes_cpu_clk <= 1'b1;
    if (!wr) push_check(K_SNES, s, shadow[m[15:0]]);
    repeat (11) @(posedge CLK2);
    push_check(K_BUS, s, 8'h01);  // Strobes idle, transceiver closed
    @(posedge CLK2);
    if (wr) begin
      if (in_saveram(s)) shadow[m[15:0]] = d;  // ROM stays untouched
      push_check(K_MEM, m, shadow[m[15:0]]);
    end
  endtask

  task automatic mcu_access(input logic wr, input snes_addr_t s, input byte_t d);
    int n;
    mcu_addr <= s;
    mcu_dout <= d;
    if (wr) mcu_wrq <= 1'b1;
    else mcu_rrq <= 1'b1;
    @(posedge CLK2);
    mcu_rrq <= 1'b0;
    mcu_wrq <= 1'b0;
    n = 0;
    do begin
      @(negedge CLK2);
      n++;
    end while (!mcu_rdy && n < 300);
    if (!mcu_rdy) abort_run("MCU request never completed, mcu_rdy stayed low");
    @(posedge CLK2);
    if (wr) begin
      shadow[s[15:0]] = d;
      push_check(K_MEM, s, d);
    end else begin
      push_check(K_MCU, s, shadow[s[15:0]]);
    end
  endtask

  initial begin
    repeat (N_TESTS * 400) @(posedge CLK2);
    abort_run("Timeout, the test sequence did not finish");
  end

  initial begin
    seed = 32'h9c955e7d;
    for (int i = 0; i < 32768; i++) begin
      w = fill_word(i[14:0]);
      shadow[{i[14:0], 1'b0}] = w[15:8];
      shadow[{i[14:0], 1'b1}] = w[7:0];
    end
    rst_n        <= 1'b0;
    snes_addr_in <= '0;
    snes_rd_n    <= 1'b1;
    snes_wr_n    <= 1'b1;
    snes_cs_n    <= 1'b0;
    snes_cpu_clk <= 1'b1;
    snes_din     <= '0;
    mcu_rrq      <= 1'b0;
    mcu_wrq      <= 1'b0;
    mcu_addr     <= '0;
    mcu_dout     <= '0;
    rom_mask     <= ROM_MASK;
    saveram_mask <= SRAM_MASK;
    repeat (5) @(posedge CLK2);
    rst_n <= 1'b1;
    @(posedge CLK2);
    push_check(K_RESET, '0, 8'h0C);
    repeat (2) @(posedge CLK2);  // CPU clock history fills with highs

    for (int i = 0; i < N_RD; i++) begin
      r = $random(seed);
      a = r[23:0];
      a[15] = 1'b1;  // Upper half is always ROM
      snes_cs_n <= r[31];
      snes_cycle(a, 1'b0, 8'h00);
    end
    snes_cs_n <= 1'b0;

    // Save RAM writes alternate with writes into ROM space
    for (int i = 0; i < N_WR; i++) begin
      r = $random(seed);
      if (i[0]) a = {8'h70 + {4'h0, r[27:24] % 4'd14}, 1'b0, r[14:0]};
      else a = {r[23:16], 1'b1, r[14:0]};
      wr_addrs.push_back(a);
      snes_cycle(a, 1'b1, r[7:0] ^ r[31:24]);
    end
    while (wr_addrs.size() > 0) snes_cycle(wr_addrs.pop_front(), 1'b0, 8'h00);

    // Console stopped, MCU owns the PSRAM
    snes_cpu_clk <= 1'b0;
    repeat (60) @(posedge CLK2);
    for (int i = 0; i < N_MCU; i++) begin
      r = $random(seed);
      mcu_access(r[31], r[23:0], r[7:0] ^ r[30:23]);
    end
    snes_cpu_clk <= 1'b1;
    repeat (12) @(posedge CLK2);

    for (int i = 0; i < N_MIX; i++) begin
      r = $random(seed);
      a = {r[31:24], 1'b1, r[14:0]};
      fork
        snes_cycle(a, 1'b0, 8'h00);
        mcu_access(i[0], {r[7:0], r[23:8]}, r[19:12]);
      join
      snes_cycle({a[23:16], a[15:0] ^ 16'h0001}, 1'b0, 8'h00);
    end

    repeat (4) @(posedge CLK2);
    if (chk_q.size() == 0) begin
      $display("All tests passed");
      $finish;
    end else begin
      abort_run("Checks were left in the queue at the end of the run");
    end
  end

endmodule

`default_nettype wire

/* test/cart_main_sva.sv */
`timescale 1ns/1ps
`default_nettype none

module cart_main_sva
  import cart_pkg::*;
(
  input logic       CLK2,
  input logic       rst_n,
  input arb_state_e state,
  input logic       we_n,
  input logic       dout_en,
  input logic       mcu_rdy,
  input mcu_req_t   mcu
);

  logic in_end;

  assign in_end = (state == mcu_rd_end) || (state == mcu_wr_end);

  ////////////////////
  // PSRAM write strobe

  a_idle_no_write: assert property (@(posedge CLK2) disable iff (!rst_n)
    (state == idle) |-> we_n)
    else $error("PSRAM write strobe low while the arbiter is idle");

  // Write data must be driven for the whole strobe
  a_write_drives: assert property (@(posedge CLK2) disable iff (!rst_n)
    !we_n |-> dout_en)
    else $error("PSRAM write strobe low without data output enable");

  ////////////////////
  // MCU ready

  a_req_drops_rdy: assert property (@(posedge CLK2) disable iff (!rst_n)
    (mcu.rrq || mcu.wrq) |=> !mcu_rdy)
    else $error("mcu_rdy did not drop after a request");

  a_rdy_held_low: assert property (@(posedge CLK2) disable iff (!rst_n)
    (!mcu_rdy && !in_end) |=> !mcu_rdy)
    else $error("mcu_rdy rose before the MCU end state");

endmodule

bind rom_arbiter cart_main_sva u_sva (
  .CLK2, .rst_n, .state, .we_n, .dout_en, .mcu_rdy, .mcu
);

`default_nettype wire

/* rtl/cart_main.sv */
`timescale 1ns/1ps
`default_nettype none

module cart_main
  import cart_pkg::*;
#(
  parameter logic [DEAD_CNT_W-1:0] DEAD_TIMEOUT = 18'd88000  // About 1 ms of CLK2
) (
  input  logic           CLK2,
  input  logic           rst_n,
  // SNES
  input  snes_addr_t     snes_addr_in,
  input  logic           snes_rd_n,
  input  logic           snes_wr_n,
  input  logic           snes_cs_n,
  input  logic           snes_cpu_clk,
  input  byte_t          snes_din,
  output byte_t          snes_dout,
  output logic           snes_dout_en,
  output logic           snes_databus_oe_n,
  output logic           snes_databus_dir,
  // PSRAM
  output rom_word_addr_t rom_addr,
  input  rom_word_t      rom_dq_in,
  output rom_word_t      rom_dq_out,
  output logic           rom_dq_oe,
  output logic           rom_we_n,
  output logic           rom_bhe_n,
  output logic           rom_ble_n,
  // MCU
  input  logic           mcu_rrq,
  input  logic           mcu_wrq,
  input  snes_addr_t     mcu_addr,
  input  byte_t          mcu_dout,
  output byte_t          mcu_din,
  output logic           mcu_rdy,
  // Configuration
  input  snes_addr_t     rom_mask,
  input  snes_addr_t     saveram_mask
);

  snes_bus_t  bus;
  map_t       map;
  mcu_req_t   mcu_req;
  logic       use_snes_addr;
  snes_addr_t mcu_addr_q;
  byte_t      wr_byte;
  logic       we_n;
  logic       dout_en;
  byte_t      rd_byte;
  logic       strobe_active;

  assign mcu_req = '{rrq: mcu_rrq, wrq: mcu_wrq, addr: mcu_addr, data: mcu_dout};

  snes_bus_sync #(.DEAD_TIMEOUT(DEAD_TIMEOUT)) u_sync (
    .CLK2, .rst_n, .snes_addr_in, .snes_rd_n, .snes_wr_n, .snes_cpu_clk, .bus
  );

  cart_map u_map (.bus, .rom_mask, .saveram_mask, .map);

  rom_arbiter u_arb (
    .CLK2, .rst_n, .bus, .map, .mcu(mcu_req), .snes_din, .rd_byte,
    .snes_dout, .mcu_din, .mcu_rdy, .use_snes_addr, .mcu_addr_q,
    .wr_byte, .we_n, .dout_en
  );

  psram_port u_port (
    .use_snes_addr, .map, .mcu_addr_q, .wr_byte, .we_n, .dout_en, .rom_dq_in,
    .rom_addr, .rom_dq_out, .rom_dq_oe, .rom_we_n, .rom_bhe_n, .rom_ble_n, .rd_byte
  );

  ////////////////////
  // Data bus transceiver
  assign strobe_active     = !(bus.rd_n_q & bus.wr_n_q);
  assign snes_dout_en      = !bus.rd_n;
  assign snes_databus_dir  = !bus.rd_n_q;  // High drives toward the SNES
  assign snes_databus_oe_n = !(((map.is_rom & !snes_cs_n) | map.is_saveram) & strobe_active);

endmodule

`default_nettype wire

/* rtl/psram_port.sv */
`timescale 1ns/1ps
`default_nettype none

module psram_port
  import cart_pkg::*;
(
  input  logic           use_snes_addr,
  input  map_t           map,
  input  snes_addr_t     mcu_addr_q,
  input  byte_t          wr_byte,
  input  logic           we_n,
  input  logic           dout_en,
  input  rom_word_t      rom_dq_in,
  output rom_word_addr_t rom_addr,
  output rom_word_t      rom_dq_out,
  output logic           rom_dq_oe,
  output logic           rom_we_n,
  output logic           rom_bhe_n,
  output logic           rom_ble_n,
  output byte_t          rd_byte
);

  snes_addr_t byte_addr;
  logic       odd;

  // SNES side owns the bus unless an MCU access is running
  assign byte_addr = use_snes_addr ? map.addr : mcu_addr_q;
  assign odd       = byte_addr[0];

  assign rom_addr = byte_addr[23:1];

  ////////////////////
  // Lane steering

  // Odd bytes live in the low lane
  assign rom_ble_n = !odd;
  assign rom_bhe_n = odd;

  assign rom_dq_out = odd ? {8'h00, wr_byte} : {wr_byte, 8'h00};
  assign rd_byte    = odd ? rom_dq_in[7:0] : rom_dq_in[15:8];

  assign rom_dq_oe = dout_en;
  assign rom_we_n  = we_n;

endmodule

`default_nettype wire

/* rtl/rom_arbiter.sv */
`timescale 1ns/1ps
`default_nettype none

module rom_arbiter
  import cart_pkg::*;
(
  input  logic       CLK2,
  input  logic       rst_n,
  input  snes_bus_t  bus,
  input  map_t       map,
  input  mcu_req_t   mcu,
  input  byte_t      snes_din,
  input  byte_t      rd_byte,
  output byte_t      snes_dout,
  output byte_t      mcu_din,
  output logic       mcu_rdy,
  output logic       use_snes_addr,
  output snes_addr_t mcu_addr_q,
  output byte_t      wr_byte,
  output logic       we_n,
  output logic       dout_en
);

  arb_state_e state;
  logic [3:0] mem_delay;
  logic       rd_pend;
  logic       wr_pend;
  byte_t      mcu_data_q;
  logic       wake;
  logic       delay_done;
  logic       mcu_done;

  // Console coming back to life while still flagged dead
  assign wake       = bus.dead & bus.cpu_clk;
  assign delay_done = (mem_delay == 4'd0);
  assign mcu_done   = ((state == mcu_rd_end) || (state == mcu_wr_end)) && !wake;

  ////////////////////
  // MCU request queue

  always_ff @(posedge CLK2 or negedge rst_n) begin
    if (!rst_n) begin
      rd_pend <= 1'b0;
      wr_pend <= 1'b0;
      mcu_rdy <= 1'b1;
    end else if (mcu.rrq) begin
      rd_pend <= 1'b1;
      mcu_rdy <= 1'b0;
    end else if (mcu.wrq) begin
      wr_pend <= 1'b1;
      mcu_rdy <= 1'b0;
    end else if (mcu_done) begin
      rd_pend <= 1'b0;
      wr_pend <= 1'b0;
      mcu_rdy <= 1'b1;  // High again one edge after the end state
    end
  end

  always_ff @(posedge CLK2) begin
    if (mcu.rrq | mcu.wrq) begin
      mcu_addr_q <= mcu.addr;
      mcu_data_q <= mcu.data;
    end
  end

  ////////////////////
  // Arbiter FSM

  always_ff @(posedge CLK2 or negedge rst_n) begin
    if (!rst_n) begin
      state         <= idle;
      mem_delay     <= 4'd0;
      use_snes_addr <= 1'b1;
      we_n          <= 1'b1;
      dout_en       <= 1'b0;
    end else if (wake) begin
      // Abort, pending MCU access restarts later
      state         <= idle;
      use_snes_addr <= 1'b1;
      we_n          <= 1'b1;
      dout_en       <= 1'b0;
    end else begin
      case (state)
        idle: begin
          use_snes_addr <= 1'b1;
          dout_en       <= 1'b0;
          if (bus.cycle_start && !bus.wr_n) begin
            state <= snes_wr_addr;
            if (map.is_saveram) begin  // ROM space is write protected
              we_n    <= 1'b0;
              dout_en <= 1'b1;
            end
          end else if (bus.cycle_start) begin
            state <= snes_rd_end;
          end else if (bus.dead && rd_pend) begin
            state <= mcu_rd_addr;
          end else if (bus.dead && wr_pend) begin
            state <= mcu_wr_addr;
          end
        end

        snes_wr_addr: begin
          mem_delay <= ROM_WR_WAIT1;
          state     <= snes_wr_wait1;
        end
        snes_wr_wait1: begin
          mem_delay <= mem_delay - 1'b1;
          if (delay_done) begin
            mem_delay <= ROM_WR_WAIT2;
            state     <= snes_wr_wait2;
          end
        end
        snes_wr_wait2: begin
          mem_delay <= mem_delay - 1'b1;
          if (delay_done) begin
            we_n  <= 1'b1;
            state <= snes_wr_end;
          end
        end

        // Slip a queued MCU access in right behind the SNES cycle
        snes_rd_end, snes_wr_end: begin
          dout_en <= 1'b0;
          if (rd_pend) begin
            state <= mcu_rd_addr;
          end else if (wr_pend) begin
            state <= mcu_wr_addr;
          end else begin
            state <= idle;
          end
        end

        mcu_rd_addr: begin
          use_snes_addr <= 1'b0;
          mem_delay     <= ROM_RD_WAIT_MCU;
          state         <= mcu_rd_wait;
        end
        mcu_rd_wait: begin
          mem_delay <= mem_delay - 1'b1;
          if (delay_done) state <= mcu_rd_end;
        end
        mcu_rd_end: begin
          state <= idle;
        end

        mcu_wr_addr: begin
          use_snes_addr <= 1'b0;
          mem_delay     <= ROM_WR_WAIT_MCU;
          we_n          <= 1'b0;
          dout_en       <= 1'b1;
          state         <= mcu_wr_wait;
        end
        mcu_wr_wait: begin
          mem_delay <= mem_delay - 1'b1;
          if (delay_done) state <= mcu_wr_end;
        end
        mcu_wr_end: begin
          we_n    <= 1'b1;  // Rising edge commits the byte
          dout_en <= 1'b0;
          state   <= idle;
        end

        default: state <= idle;
      endcase
    end
  end

  ////////////////////
  // Data latches

  always_ff @(posedge CLK2) begin
    if (!wake) begin
      case (state)
        idle:          if (bus.cycle_start && bus.wr_n) snes_dout <= rd_byte;
        snes_wr_wait1: if (delay_done) wr_byte <= snes_din;  // SNES data settled by now
        mcu_wr_addr:   wr_byte <= mcu_data_q;
        mcu_rd_end:    mcu_din <= rd_byte;
        default:       ;
      endcase
    end
  end

endmodule

`default_nettype wire

/* rtl/cart_map.sv */
`timescale 1ns/1ps
`default_nettype none

module cart_map
  import cart_pkg::*;
(
  input  snes_bus_t  bus,
  input  snes_addr_t rom_mask,
  input  snes_addr_t saveram_mask,
  output map_t       map
);

  logic [7:0] bank;
  logic       hi_half;
  logic       sram_hit;
  logic       rom_hit;
  snes_addr_t sram_addr;
  snes_addr_t rom_addr;

  assign bank    = bus.addr[23:16];
  assign hi_half = bus.addr[15];

  // Save RAM sits in banks 70-7D, lower half only
  assign sram_hit = (bank >= 8'h70) && (bank <= 8'h7D) && !hi_half;

  assign rom_hit = hi_half
                 | ((bank >= 8'h40) && (bank <= 8'h6F))
                 | (bank >= 8'hC0);

  ////////////////////
  // Address folding

  assign sram_addr = 24'hE00000
                   + ({4'h0, bus.addr[20:16], bus.addr[14:0]} & saveram_mask);

  // LoROM: 32K per bank, A15 dropped
  assign rom_addr = {2'b00, bus.addr[22:16], bus.addr[14:0]} & rom_mask;

  always_comb begin
    map.is_saveram = sram_hit;
    map.is_rom     = rom_hit & !sram_hit;
    map.addr       = sram_hit ? sram_addr : rom_addr;
  end

endmodule

`default_nettype wire

/* rtl/snes_bus_sync.sv */
`timescale 1ns/1ps
`default_nettype none

module snes_bus_sync
  import cart_pkg::*;
#(
  parameter logic [DEAD_CNT_W-1:0] DEAD_TIMEOUT = 18'd88000
) (
  input  logic       CLK2,
  input  logic       rst_n,
  input  snes_addr_t snes_addr_in,
  input  logic       snes_rd_n,
  input  logic       snes_wr_n,
  input  logic       snes_cpu_clk,
  output snes_bus_t  bus
);

  snes_addr_t            addr_s0;
  snes_addr_t            addr_s1;
  snes_addr_t            addr_s2;
  logic [7:0]            rd_hist;
  logic [7:0]            wr_hist;
  logic [7:0]            clk_hist;
  logic [5:0]            clk_filt;
  logic [DEAD_CNT_W-1:0] dead_cnt;
  logic                  dead;

  ////////////////////
  // Address synchronizer

  always_ff @(posedge CLK2) begin
    addr_s0 <= snes_addr_in;
    addr_s1 <= addr_s0;
    addr_s2 <= addr_s1;
  end

  ////////////////////
  // Strobe histories

  always_ff @(posedge CLK2 or negedge rst_n) begin
    if (!rst_n) begin
      rd_hist  <= '1;  // Strobes idle high
      wr_hist  <= '1;
      clk_hist <= '0;
    end else begin
      rd_hist  <= {rd_hist[6:0], snes_rd_n};
      wr_hist  <= {wr_hist[6:0], snes_wr_n};
      clk_hist <= {clk_hist[6:0], snes_cpu_clk};
    end
  end

  // Single-sample glitches on the CPU clock drop out here
  assign clk_filt = clk_hist[7:2] & clk_hist[6:1];

  // Dead console detection
  always_ff @(posedge CLK2 or negedge rst_n) begin
    if (!rst_n) begin
      dead_cnt <= '0;
    end else if (snes_cpu_clk) begin
      dead_cnt <= '0;
    end else if (dead_cnt != '1) begin
      dead_cnt <= dead_cnt + 1'b1;  // Saturates
    end
  end

  always_ff @(posedge CLK2 or negedge rst_n) begin
    if (!rst_n) begin
      dead <= 1'b0;
    end else if (dead_cnt > DEAD_TIMEOUT) begin
      dead <= 1'b1;
    end else if (snes_cpu_clk) begin
      dead <= 1'b0;
    end
  end

  always_comb begin
    bus.addr        = addr_s2 & addr_s1;  // Both stages must agree on a one
    bus.rd_n        = snes_rd_n;
    bus.wr_n        = snes_wr_n;
    bus.rd_n_q      = rd_hist[0];
    bus.wr_n_q      = wr_hist[0];
    bus.cycle_start = (clk_filt == 6'b100000);  // Falling CPU clock
    bus.cycle_end   = (clk_filt == 6'b011111);  // Five highs after a low
    bus.dead        = dead;
    bus.cpu_clk     = snes_cpu_clk;
  end

endmodule

`default_nettype wire

/* rtl/cart_pkg.sv */
`default_nettype none

package cart_pkg;

  ////////////////////
  // Widths

  typedef logic [23:0] snes_addr_t;      // SNES or mapped byte address
  typedef logic [22:0] rom_word_addr_t;  // PSRAM word address
  typedef logic [7:0]  byte_t;
  typedef logic [15:0] rom_word_t;       // PSRAM data word

  ////////////////////
  // Arbiter states

  typedef enum logic [3:0] {
    idle,
    snes_rd_end,
    snes_wr_addr,
    snes_wr_wait1,
    snes_wr_wait2,
    snes_wr_end,
    mcu_rd_addr,
    mcu_rd_wait,
    mcu_rd_end,
    mcu_wr_addr,
    mcu_wr_wait,
    mcu_wr_end
  } arb_state_e;

  ////////////////////
  // Bundles

  typedef struct packed {
    snes_addr_t addr;         // Synchronized address
    logic       rd_n;         // Raw strobe levels
    logic       wr_n;
    logic       rd_n_q;       // One flop behind the pins
    logic       wr_n_q;
    logic       cycle_start;  // Single-cycle pulses
    logic       cycle_end;
    logic       dead;         // CPU clock stopped
    logic       cpu_clk;      // Raw pin level
  } snes_bus_t;

  typedef struct packed {
    snes_addr_t addr;
    logic       is_rom;
    logic       is_saveram;
  } map_t;

  typedef struct packed {
    logic       rrq;
    logic       wrq;
    snes_addr_t addr;
    byte_t      data;
  } mcu_req_t;

  // Memory delays, in CLK2 cycles minus one
  localparam logic [3:0] ROM_WR_WAIT1    = 4'd2;
  localparam logic [3:0] ROM_WR_WAIT2    = 4'd1;
  localparam logic [3:0] ROM_RD_WAIT_MCU = 4'd6;
  localparam logic [3:0] ROM_WR_WAIT_MCU = 4'd5;

  localparam int DEAD_CNT_W = 18;

endpackage

`default_nettype wire
